// ==== cpuCore.f ====
logic/cpuCfgPkg.sv
logic/rvIsaPkg.sv
logic/decoder.sv
logic/registerFile.sv
logic/alu.sv
logic/forwardUnit.sv
logic/pipeReg.sv
logic/dataMemory.sv
logic/cpuTop.sv
test/cpuTopTb.sv

// ==== logic/alu.sv ====
// Arithmetic and compare unit
`timescale 1ns/100ps

module alu (
	input  logic [cpuCfgPkg::xlen-1:0] a,
	input  logic [cpuCfgPkg::xlen-1:0] b,
	input  rvIsaPkg::aluOpT aluOp,
	output logic [cpuCfgPkg::xlen-1:0] result
);

	localparam logic [cpuCfgPkg::xlen-1:0] one = 1;

	always_comb begin
		case (aluOp)
			rvIsaPkg::aluAdd: result = a + b;
			rvIsaPkg::aluSub: result = a - b;
			rvIsaPkg::aluAnd: result = a & b;
			rvIsaPkg::aluOr: result = a | b;
			rvIsaPkg::aluXor: result = a ^ b;
			rvIsaPkg::aluSlt: result = ($signed(a) < $signed(b)) ? one : '0;
			rvIsaPkg::aluPassB: result = b;
			// branch conditions, read as the taken bit
			rvIsaPkg::aluEq: result = (a == b) ? one : '0;
			rvIsaPkg::aluNe: result = (a != b) ? one : '0;
			default: result = '0;
		endcase
	end

endmodule

// ==== logic/cpuCfgPkg.sv ====
// Core configuration constants
package cpuCfgPkg;

	// data and address width
	localparam int xlen = 32;

	// register index width and count
	localparam int regIdW = 5;
	localparam int regCount = 1 << regIdW;

	// first fetch address after reset
	localparam logic [xlen-1:0] resetPc = '0;

	// sequential pc increment, one word
	localparam logic [xlen-1:0] pcStep = 4;

	// addi x0, x0, 0
	localparam logic [xlen-1:0] nopInst = 32'h0000_0013;

endpackage

// ==== logic/cpuTop.sv ====
// Five-stage pipelined core
`timescale 1ns/100ps

module cpuTop #(
	parameter int memWords = 256
) (
	input  logic clk,
	input  logic arstN,
	input  logic [cpuCfgPkg::xlen-1:0] inst,
	output logic [cpuCfgPkg::xlen-1:0] pc,
	output logic wbValid,
	output logic [cpuCfgPkg::regIdW-1:0] wbRd,
	output logic [cpuCfgPkg::xlen-1:0] wbData,
	output logic halted,
	output logic illegal
);

	wire rvIsaPkg::ifIdT ifIdIn;
	wire rvIsaPkg::idExT idExIn;
	wire rvIsaPkg::exMemT exMemIn;
	wire rvIsaPkg::memWbT memWbIn;
	rvIsaPkg::ifIdT ifIdOut;
	rvIsaPkg::idExT idExOut;
	rvIsaPkg::exMemT exMemOut;
	rvIsaPkg::memWbT memWbOut;
	logic ifIdValid;
	logic idExValid;
	logic exMemValid;
	logic memWbValid;

	logic [cpuCfgPkg::regIdW-1:0] decRs1;
	logic [cpuCfgPkg::regIdW-1:0] decRs2;
	logic [cpuCfgPkg::xlen-1:0] rData1;
	logic [cpuCfgPkg::xlen-1:0] rData2;
	logic [1:0] fwd1;
	logic [1:0] fwd2;

	logic [cpuCfgPkg::xlen-1:0] exOpA;
	logic [cpuCfgPkg::xlen-1:0] exOpB;
	logic [cpuCfgPkg::xlen-1:0] aluResult;
	logic [cpuCfgPkg::xlen-1:0] exData;
	logic [cpuCfgPkg::xlen-1:0] target;
	logic [cpuCfgPkg::xlen-1:0] memRData;
	logic [cpuCfgPkg::xlen-1:0] memStageData;
	logic redirect;
	logic haltNow;
	logic haltedQ;
	logic illegalQ;
	logic stopAll;

	function automatic logic [cpuCfgPkg::xlen-1:0] pickOperand(
		input logic [1:0] sel,
		input logic [cpuCfgPkg::xlen-1:0] rfValue,
		input logic [cpuCfgPkg::xlen-1:0] exValue,
		input logic [cpuCfgPkg::xlen-1:0] memValue
	);
		case (sel)
			rvIsaPkg::fwdEx: return exValue;
			rvIsaPkg::fwdMem: return memValue;
			default: return rfValue;
		endcase
	endfunction

	// fetch, a squashed slot becomes a nop
	assign ifIdIn.pc = pc;
	assign ifIdIn.inst = (redirect || stopAll) ? cpuCfgPkg::nopInst : inst;

	pipeReg #(.payloadT(rvIsaPkg::ifIdT)) ifId (
		.clk(clk),
		.arstN(arstN),
		.flush(redirect || stopAll),
		.inValid(1'b1),
		.inData(ifIdIn),
		.outValid(ifIdValid),
		.outData(ifIdOut)
	);

	// decode
	decoder dec (
		.inst(ifIdOut.inst),
		.rs1(decRs1),
		.rs2(decRs2),
		.rd(idExIn.rd),
		.imm(idExIn.imm),
		.aluOp(idExIn.aluOp),
		.regWen(idExIn.regWen),
		.memWen(idExIn.memWen),
		.isLoad(idExIn.isLoad),
		.isBranch(idExIn.isBranch),
		.isJump(idExIn.isJump),
		.isJalr(idExIn.isJalr),
		.useImm(idExIn.useImm),
		.isLui(idExIn.isLui),
		.halt(idExIn.halt),
		.illegal(idExIn.illegal)
	);

	registerFile regs (
		.clk(clk),
		.arstN(arstN),
		.wen(memWbValid && memWbOut.regWen),
		.wAddr(memWbOut.rd),
		.wData(memWbOut.data),
		.rAddr1(decRs1),
		.rAddr2(decRs2),
		.rData1(rData1),
		.rData2(rData2)
	);

	forwardUnit fwd (
		.rs1(decRs1),
		.rs2(decRs2),
		.exRd(idExOut.rd),
		.exWen(idExValid && idExOut.regWen),
		.exIsLoad(idExOut.isLoad),
		.memRd(exMemOut.rd),
		.memWen(exMemValid && exMemOut.regWen),
		.fwd1(fwd1),
		.fwd2(fwd2),
		.loadFwd1(idExIn.ldFwd1),
		.loadFwd2(idExIn.ldFwd2)
	);

	assign idExIn.op1 = pickOperand(fwd1, rData1, exData, memStageData);
	assign idExIn.op2 = pickOperand(fwd2, rData2, exData, memStageData);
	assign idExIn.pc = ifIdOut.pc;

	pipeReg #(.payloadT(rvIsaPkg::idExT)) idEx (
		.clk(clk),
		.arstN(arstN),
		.flush(redirect || stopAll),
		.inValid(ifIdValid),
		.inData(idExIn),
		.outValid(idExValid),
		.outData(idExOut)
	);

	// execute, a load one stage ahead overrides the latched operand
	assign exOpA = idExOut.ldFwd1 ? memRData : idExOut.op1;
	assign exOpB = idExOut.ldFwd2 ? memRData : idExOut.op2;

	alu exAlu (
		.a(idExOut.isLui ? '0 : exOpA),
		.b(idExOut.useImm ? idExOut.imm : exOpB),
		.aluOp(idExOut.aluOp),
		.result(aluResult)
	);

	// jumps write the link address
	assign exData = (idExOut.isJump || idExOut.isJalr) ?
		idExOut.pc + cpuCfgPkg::pcStep : aluResult;
	assign redirect = idExValid &&
		(idExOut.isJump || idExOut.isJalr || (idExOut.isBranch && aluResult[0]));
	assign target = idExOut.isJalr ?
		{aluResult[cpuCfgPkg::xlen-1:1], 1'b0} : idExOut.pc + idExOut.imm;

	assign exMemIn.rd = idExOut.rd;
	assign exMemIn.regWen = idExOut.regWen;
	assign exMemIn.memWen = idExOut.memWen;
	assign exMemIn.isLoad = idExOut.isLoad;
	assign exMemIn.halt = idExOut.halt;
	assign exMemIn.illegal = idExOut.illegal;
	assign exMemIn.result = exData;
	assign exMemIn.storeData = exOpB;

	pipeReg #(.payloadT(rvIsaPkg::exMemT)) exMem (
		.clk(clk),
		.arstN(arstN),
		.flush(stopAll),
		.inValid(idExValid),
		.inData(exMemIn),
		.outValid(exMemValid),
		.outData(exMemOut)
	);

	// memory
	dataMemory #(.memWords(memWords)) dmem (
		.clk(clk),
		.wen(exMemValid && exMemOut.memWen && !stopAll),
		.addr(exMemOut.result),
		.wData(exMemOut.storeData),
		.rData(memRData)
	);

	assign memStageData = exMemOut.isLoad ? memRData : exMemOut.result;

	assign memWbIn.rd = exMemOut.rd;
	assign memWbIn.regWen = exMemOut.regWen;
	assign memWbIn.halt = exMemOut.halt;
	assign memWbIn.illegal = exMemOut.illegal;
	assign memWbIn.data = memStageData;

	pipeReg #(.payloadT(rvIsaPkg::memWbT)) memWb (
		.clk(clk),
		.arstN(arstN),
		.flush(stopAll),
		.inValid(exMemValid),
		.inData(memWbIn),
		.outValid(memWbValid),
		.outData(memWbOut)
	);

	// writeback report
	assign wbValid = memWbValid && memWbOut.regWen && memWbOut.rd != '0;
	assign wbRd = memWbOut.rd;
	assign wbData = memWbOut.data;

	// halting instruction in writeback freezes everything younger
	assign haltNow = memWbValid && memWbOut.halt;
	assign stopAll = haltNow || haltedQ;
	assign halted = stopAll;
	assign illegal = illegalQ || (haltNow && memWbOut.illegal);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= cpuCfgPkg::resetPc;
			haltedQ <= 1'b0;
			illegalQ <= 1'b0;
		end else begin
			haltedQ <= stopAll;
			illegalQ <= illegal;
			if (!stopAll) begin
				pc <= redirect ? target : pc + cpuCfgPkg::pcStep;
			end
		end
	end

endmodule

// ==== logic/dataMemory.sv ====
// Word-addressed data RAM
`timescale 1ns/100ps

module dataMemory #(
	parameter int memWords = 256
) (
	input  logic clk,
	input  logic wen,
	input  logic [cpuCfgPkg::xlen-1:0] addr,
	input  logic [cpuCfgPkg::xlen-1:0] wData,
	output logic [cpuCfgPkg::xlen-1:0] rData
);

	localparam int idxW = $clog2(memWords);

	logic [cpuCfgPkg::xlen-1:0] mem [memWords];
	logic [idxW-1:0] index;

	// byte offset dropped, upper bits wrap
	assign index = addr[idxW+1:2];

	assign rData = mem[index];

	always_ff @(posedge clk) begin
		if (wen) begin
			mem[index] <= wData;
		end
	end

endmodule

// ==== logic/decoder.sv ====
// Instruction decoder
`timescale 1ns/100ps

module decoder (
	input  logic [cpuCfgPkg::xlen-1:0] inst,
	output logic [cpuCfgPkg::regIdW-1:0] rs1,
	output logic [cpuCfgPkg::regIdW-1:0] rs2,
	output logic [cpuCfgPkg::regIdW-1:0] rd,
	output logic [cpuCfgPkg::xlen-1:0] imm,
	output rvIsaPkg::aluOpT aluOp,
	output logic regWen,
	output logic memWen,
	output logic isLoad,
	output logic isBranch,
	output logic isJump,
	output logic isJalr,
	output logic useImm,
	output logic isLui,
	output logic halt,
	output logic illegal
);

	rvIsaPkg::opcodeT opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [cpuCfgPkg::xlen-1:0] immI;
	logic [cpuCfgPkg::xlen-1:0] immS;
	logic [cpuCfgPkg::xlen-1:0] immB;
	logic [cpuCfgPkg::xlen-1:0] immU;
	logic [cpuCfgPkg::xlen-1:0] immJ;
	logic bad;

	assign opcode = rvIsaPkg::opcodeT'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign rd = inst[11:7];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		imm = '0;
		aluOp = rvIsaPkg::aluAdd;
		regWen = 1'b0;
		memWen = 1'b0;
		isLoad = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		isJalr = 1'b0;
		useImm = 1'b0;
		isLui = 1'b0;
		halt = 1'b0;
		bad = 1'b0;
		case (opcode)
			rvIsaPkg::opLui: begin
				imm = immU;
				aluOp = rvIsaPkg::aluPassB;
				regWen = 1'b1;
				useImm = 1'b1;
				isLui = 1'b1;
			end
			rvIsaPkg::opImm: begin
				// addi is the only immediate operation kept
				imm = immI;
				regWen = 1'b1;
				useImm = 1'b1;
				bad = funct3 != rvIsaPkg::f3AddSub;
			end
			rvIsaPkg::opReg: begin
				regWen = 1'b1;
				case (funct3)
					rvIsaPkg::f3AddSub: aluOp = (funct7 == rvIsaPkg::f7Alt) ?
						rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
					rvIsaPkg::f3Slt: aluOp = rvIsaPkg::aluSlt;
					rvIsaPkg::f3Xor: aluOp = rvIsaPkg::aluXor;
					rvIsaPkg::f3Or: aluOp = rvIsaPkg::aluOr;
					rvIsaPkg::f3And: aluOp = rvIsaPkg::aluAnd;
					default: bad = 1'b1;
				endcase
				// only sub uses the alternate funct7
				if (funct7 != rvIsaPkg::f7Base &&
					!(funct7 == rvIsaPkg::f7Alt && funct3 == rvIsaPkg::f3AddSub)) begin
					bad = 1'b1;
				end
			end
			rvIsaPkg::opLoad: begin
				imm = immI;
				regWen = 1'b1;
				isLoad = 1'b1;
				useImm = 1'b1;
				bad = funct3 != rvIsaPkg::f3Word;
			end
			rvIsaPkg::opStore: begin
				imm = immS;
				memWen = 1'b1;
				useImm = 1'b1;
				bad = funct3 != rvIsaPkg::f3Word;
			end
			rvIsaPkg::opBranch: begin
				imm = immB;
				isBranch = 1'b1;
				case (funct3)
					rvIsaPkg::f3Beq: aluOp = rvIsaPkg::aluEq;
					rvIsaPkg::f3Bne: aluOp = rvIsaPkg::aluNe;
					default: bad = 1'b1;
				endcase
			end
			rvIsaPkg::opJal: begin
				imm = immJ;
				regWen = 1'b1;
				isJump = 1'b1;
			end
			rvIsaPkg::opJalr: begin
				imm = immI;
				regWen = 1'b1;
				isJalr = 1'b1;
				useImm = 1'b1;
				bad = funct3 != rvIsaPkg::f3AddSub;
			end
			rvIsaPkg::opSystem: begin
				halt = inst == rvIsaPkg::ebreakInst;
				bad = inst != rvIsaPkg::ebreakInst;
			end
			default: bad = 1'b1;
		endcase
		// unimplemented encodings halt without side effects
		if (bad) begin
			regWen = 1'b0;
			memWen = 1'b0;
			isLoad = 1'b0;
			isBranch = 1'b0;
			isJump = 1'b0;
			isJalr = 1'b0;
			halt = 1'b1;
		end
		illegal = bad;
	end

endmodule

// ==== logic/forwardUnit.sv ====
// Operand forwarding selection
`timescale 1ns/100ps

module forwardUnit (
	input  logic [cpuCfgPkg::regIdW-1:0] rs1,
	input  logic [cpuCfgPkg::regIdW-1:0] rs2,
	input  logic [cpuCfgPkg::regIdW-1:0] exRd,
	input  logic exWen,
	input  logic exIsLoad,
	input  logic [cpuCfgPkg::regIdW-1:0] memRd,
	input  logic memWen,
	output logic [1:0] fwd1,
	output logic [1:0] fwd2,
	output logic loadFwd1,
	output logic loadFwd2
);

	// returns {load flag, select} for one source index
	function automatic logic [2:0] route(input logic [cpuCfgPkg::regIdW-1:0] rs);
		logic exHit;
		logic memHit;
		logic [2:0] pick;
		exHit = exWen && rs == exRd && rs != '0;
		memHit = memWen && rs == memRd && rs != '0;
		if (exHit && exIsLoad) begin
			// data only exists next cycle, execute takes it from memory
			pick = {1'b1, rvIsaPkg::fwdRegFile};
		end else if (exHit) begin
			pick = {1'b0, rvIsaPkg::fwdEx};
		end else if (memHit) begin
			pick = {1'b0, rvIsaPkg::fwdMem};
		end else begin
			pick = {1'b0, rvIsaPkg::fwdRegFile};
		end
		return pick;
	endfunction

	always_comb begin
		{loadFwd1, fwd1} = route(rs1);
		{loadFwd2, fwd2} = route(rs2);
	end

endmodule

// ==== logic/pipeReg.sv ====
// Pipeline stage register
`timescale 1ns/100ps

module pipeReg #(
	parameter type payloadT = logic [31:0]
) (
	input  logic clk,
	input  logic arstN,
	input  logic flush,
	input  logic inValid,
	input  payloadT inData,
	output logic outValid,
	output payloadT outData
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= inValid && !flush;
		end
	end

	// payload is don't-care while invalid
	always_ff @(posedge clk) begin
		outData <= inData;
	end

endmodule

// ==== logic/registerFile.sv ====
// Integer register file
`timescale 1ns/100ps

module registerFile (
	input  logic clk,
	input  logic arstN,
	input  logic wen,
	input  logic [cpuCfgPkg::regIdW-1:0] wAddr,
	input  logic [cpuCfgPkg::xlen-1:0] wData,
	input  logic [cpuCfgPkg::regIdW-1:0] rAddr1,
	input  logic [cpuCfgPkg::regIdW-1:0] rAddr2,
	output logic [cpuCfgPkg::xlen-1:0] rData1,
	output logic [cpuCfgPkg::xlen-1:0] rData2
);

	// x0 has no storage
	logic [cpuCfgPkg::xlen-1:0] regs [1:cpuCfgPkg::regCount-1];

	function automatic logic [cpuCfgPkg::xlen-1:0] readReg(
		input logic [cpuCfgPkg::regIdW-1:0] addr
	);
		logic [cpuCfgPkg::xlen-1:0] value;
		if (addr == '0) begin
			value = '0;
		end else if (wen && addr == wAddr) begin
			// write-through from writeback
			value = wData;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		rData1 = readReg(rAddr1);
		rData2 = readReg(rAddr2);
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < cpuCfgPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wAddr != '0) begin
			regs[wAddr] <= wData;
		end
	end

endmodule

// ==== logic/rvIsaPkg.sv ====
// RV32I subset encodings and stage bundles
package rvIsaPkg;

	// major opcodes of the subset
	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opReg    = 7'b0110011,
		opSystem = 7'b1110011
	} opcodeT;

	// funct3 values
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;
	localparam logic [2:0] f3Beq    = 3'b000;
	localparam logic [2:0] f3Bne    = 3'b001;
	localparam logic [2:0] f3Word   = 3'b010;

	// funct7 values
	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Alt  = 7'b0100000;

	localparam logic [31:0] ebreakInst = 32'h0010_0073;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluPassB,
		aluEq,
		aluNe
	} aluOpT;

	// operand source selects
	localparam logic [1:0] fwdRegFile = 2'd0;
	localparam logic [1:0] fwdEx      = 2'd1;
	localparam logic [1:0] fwdMem     = 2'd2;

	typedef struct packed {
		logic [cpuCfgPkg::xlen-1:0] pc;
		logic [cpuCfgPkg::xlen-1:0] inst;
	} ifIdT;

	typedef struct packed {
		aluOpT aluOp;
		logic regWen;
		logic memWen;
		logic isLoad;
		logic isBranch;
		logic isJump;
		logic isJalr;
		logic useImm;
		logic isLui;
		logic halt;
		logic illegal;
		// operand arrives from a load one stage ahead
		logic ldFwd1;
		logic ldFwd2;
		logic [cpuCfgPkg::regIdW-1:0] rd;
		logic [cpuCfgPkg::xlen-1:0] op1;
		logic [cpuCfgPkg::xlen-1:0] op2;
		logic [cpuCfgPkg::xlen-1:0] imm;
		logic [cpuCfgPkg::xlen-1:0] pc;
	} idExT;

	typedef struct packed {
		logic [cpuCfgPkg::regIdW-1:0] rd;
		logic regWen;
		logic memWen;
		logic isLoad;
		logic halt;
		logic illegal;
		logic [cpuCfgPkg::xlen-1:0] result;
		logic [cpuCfgPkg::xlen-1:0] storeData;
	} exMemT;

	typedef struct packed {
		logic [cpuCfgPkg::regIdW-1:0] rd;
		logic regWen;
		logic halt;
		logic illegal;
		logic [cpuCfgPkg::xlen-1:0] data;
	} memWbT;

endpackage

// ==== test/cpuTopTb.sv ====
// Pipelined core testbench
`timescale 1ns/100ps

module cpuTopTb;

	localparam int wbTimeout = 40;
	localparam int haltTimeout = 40;
	localparam int holdCycles = 4;

	logic clk;
	logic arstN;
	logic [cpuCfgPkg::xlen-1:0] inst;
	logic [cpuCfgPkg::xlen-1:0] pc;
	logic wbValid;
	logic [cpuCfgPkg::regIdW-1:0] wbRd;
	logic [cpuCfgPkg::xlen-1:0] wbData;
	logic halted;
	logic illegal;

	// program words, and expected writebacks in retirement order
	logic [31:0] prog [$];
	string expName [$];
	logic [cpuCfgPkg::regIdW-1:0] expRd [$];
	logic [31:0] expData [$];

	cpuTop #(.memWords(64)) UUT (
		.clk(clk),
		.arstN(arstN),
		.inst(inst),
		.pc(pc),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData),
		.halted(halted),
		.illegal(illegal)
	);

	always #50 clk = ~clk;

	// instruction encoders
	function automatic logic [31:0] rType(input logic [6:0] f7, input int rd,
		input logic [2:0] f3, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rvIsaPkg::opReg};
	endfunction

	function automatic logic [31:0] iType(input rvIsaPkg::opcodeT op, input int rd,
		input logic [2:0] f3, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
		return iType(rvIsaPkg::opImm, rd, rvIsaPkg::f3AddSub, rs1, imm);
	endfunction

	function automatic logic [31:0] sType(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], rvIsaPkg::f3Word, imm[4:0], rvIsaPkg::opStore};
	endfunction

	function automatic logic [31:0] bType(input logic [2:0] f3, input int rs1, input int rs2,
		input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
			rvIsaPkg::opBranch};
	endfunction

	function automatic logic [31:0] uType(input int rd, input logic [19:0] upper);
		return {upper, rd[4:0], rvIsaPkg::opLui};
	endfunction

	function automatic logic [31:0] jType(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rvIsaPkg::opJal};
	endfunction

	function automatic logic [31:0] ebreakWord();
		return iType(rvIsaPkg::opSystem, 0, 3'b000, 0, 1);
	endfunction

	// words past the end of the program read as ebreak
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		int idx;
		idx = addr[31:2];
		if (idx < prog.size()) begin
			return prog[idx];
		end
		return ebreakWord();
	endfunction

	// ROM answers the current pc half a cycle later
	always @(negedge clk) begin
		inst <= fetchWord(pc);
	end

	task automatic clearTables();
		prog.delete();
		expName.delete();
		expRd.delete();
		expData.delete();
	endtask

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic expectWb(input string name, input int rd, input logic [31:0] value);
		expName.push_back(name);
		expRd.push_back(rd[4:0]);
		expData.push_back(value);
	endtask

	function automatic int currentAddr();
		return prog.size() * 4;
	endfunction

	task automatic stopOnFailure();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic buildMainProgram();
		int base;
		clearTables();
		// alu chain, each step reads the previous result
		emit(uType(1, 20'h0F0F0));
		expectWb("lui x1", 1, 32'h0F0F_0000);
		emit(addi(2, 1, 'h0F0));
		expectWb("addi x2", 2, 32'h0F0F_00F0);
		emit(rType(rvIsaPkg::f7Base, 3, rvIsaPkg::f3AddSub, 2, 1));
		expectWb("add x3", 3, 32'h1E1E_00F0);
		emit(rType(rvIsaPkg::f7Alt, 4, rvIsaPkg::f3AddSub, 2, 3));
		expectWb("sub x4", 4, 32'hF0F1_0000);
		emit(rType(rvIsaPkg::f7Base, 5, rvIsaPkg::f3And, 4, 3));
		expectWb("and x5", 5, 32'h1010_0000);
		emit(rType(rvIsaPkg::f7Base, 6, rvIsaPkg::f3Or, 5, 2));
		expectWb("or x6", 6, 32'h1F1F_00F0);
		emit(rType(rvIsaPkg::f7Base, 7, rvIsaPkg::f3Xor, 6, 3));
		expectWb("xor x7", 7, 32'h0101_0000);
		// signed compare, x4 is negative
		emit(rType(rvIsaPkg::f7Base, 8, rvIsaPkg::f3Slt, 4, 7));
		expectWb("slt x8", 8, 32'd1);
		emit(rType(rvIsaPkg::f7Base, 9, rvIsaPkg::f3Slt, 7, 4));
		expectWb("slt x9", 9, 32'd0);
		emit(addi(10, 9, -5));
		expectWb("addi x10", 10, 32'hFFFF_FFFB);
		// x0 ignores writes and reads zero
		emit(addi(0, 0, 55));
		emit(rType(rvIsaPkg::f7Base, 11, rvIsaPkg::f3AddSub, 0, 10));
		expectWb("add x11 from x0", 11, 32'hFFFF_FFFB);
		// store then load, load result used at once
		emit(addi(12, 0, 'h40));
		expectWb("addi x12", 12, 32'h0000_0040);
		emit(sType(6, 12, 0));
		emit(iType(rvIsaPkg::opLoad, 13, rvIsaPkg::f3Word, 12, 0));
		expectWb("lw x13", 13, 32'h1F1F_00F0);
		emit(rType(rvIsaPkg::f7Base, 14, rvIsaPkg::f3AddSub, 13, 12));
		expectWb("add x14 after load", 14, 32'h1F1F_0130);
		emit(sType(14, 12, 4));
		emit(iType(rvIsaPkg::opLoad, 15, rvIsaPkg::f3Word, 12, 4));
		expectWb("lw x15", 15, 32'h1F1F_0130);
		emit(rType(rvIsaPkg::f7Base, 16, rvIsaPkg::f3AddSub, 15, 15));
		expectWb("add x16 after load", 16, 32'h3E3E_0260);
		// branches, shadow slots write markers that must never retire
		emit(addi(17, 0, 7));
		expectWb("addi x17", 17, 32'd7);
		emit(bType(rvIsaPkg::f3Beq, 17, 12, 8));
		emit(bType(rvIsaPkg::f3Bne, 17, 12, 12));
		emit(addi(18, 0, 'h111));
		emit(addi(19, 0, 'h222));
		emit(bType(rvIsaPkg::f3Beq, 17, 17, 12));
		emit(addi(18, 0, 'h333));
		emit(addi(19, 0, 'h444));
		emit(addi(18, 0, 'h555));
		expectWb("addi x18 at beq target", 18, 32'h0000_0555);
		emit(bType(rvIsaPkg::f3Bne, 18, 18, 8));
		emit(addi(19, 0, 'h666));
		expectWb("addi x19 after bne", 19, 32'h0000_0666);
		// jumps link pc + 4
		base = currentAddr();
		emit(jType(20, 12));
		expectWb("jal x20 link", 20, base + 4);
		emit(addi(21, 0, 'h7AA));
		emit(addi(21, 0, 'h7BB));
		// odd target, jalr clears bit 0
		emit(addi(22, 0, base + 33));
		expectWb("addi x22", 22, base + 33);
		emit(iType(rvIsaPkg::opJalr, 23, rvIsaPkg::f3AddSub, 22, 0));
		expectWb("jalr x23 link", 23, base + 20);
		emit(addi(21, 0, 'h7CC));
		emit(addi(21, 0, 'h7DD));
		emit(addi(21, 0, 'h7EE));
		emit(addi(24, 23, 1));
		expectWb("addi x24 at jalr target", 24, base + 21);
		emit(ebreakWord());
	endtask

	task automatic buildIllegalProgram();
		clearTables();
		emit(addi(1, 0, 9));
		expectWb("addi x1 before illegal", 1, 32'd9);
		// sll, outside the subset
		emit(rType(rvIsaPkg::f7Base, 2, 3'b001, 1, 1));
		emit(addi(3, 0, 3));
	endtask

	task automatic applyReset();
		arstN = 1'b0;
		repeat (5) @(negedge clk);
		compareValue("reset pc", cpuCfgPkg::resetPc, pc);
		compareValue("reset wbValid", 0, wbValid);
		compareValue("reset halted", 0, halted);
		compareValue("reset illegal", 0, illegal);
		arstN = 1'b1;
	endtask

	task automatic checkWritebacks();
		int cycles;
		for (int i = 0; i < expRd.size(); i++) begin
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
				if (!wbValid && halted) begin
					$display("core halted before writeback %s", expName[i]);
					stopOnFailure();
				end
				if (!wbValid && cycles >= wbTimeout) begin
					$display("writeback %s did not arrive in %0d cycles", expName[i], cycles);
					stopOnFailure();
				end
			end while (!wbValid);
			compareValue({expName[i], " rd"}, expRd[i], wbRd);
			compareValue({expName[i], " data"}, expData[i], wbData);
		end
	endtask

	task automatic checkHalt(input logic expectIllegal);
		int cycles;
		logic [31:0] heldPc;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (wbValid) begin
				$display("unexpected writeback to x%0d before the halt", wbRd);
				stopOnFailure();
			end
			if (!halted && cycles >= haltTimeout) begin
				$display("core never halted within %0d cycles", cycles);
				stopOnFailure();
			end
		end while (!halted);
		compareValue("illegal at halt", expectIllegal, illegal);
		heldPc = pc;
		// nothing moves once halted
		for (int i = 0; i < holdCycles; i++) begin
			@(negedge clk);
			compareValue("halted level", 1, halted);
			compareValue("pc after halt", heldPc, pc);
			compareValue("wbValid after halt", 0, wbValid);
			compareValue("illegal after halt", expectIllegal, illegal);
		end
	endtask

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		inst = cpuCfgPkg::nopInst;
		buildMainProgram();
		applyReset();
		checkWritebacks();
		checkHalt(1'b0);
		// second run stops on an unimplemented encoding
		buildIllegalProgram();
		applyReset();
		checkWritebacks();
		checkHalt(1'b1);
		$display("All tests passed!");
		$finish;
	end

endmodule
